/* rtl/dataStore.sv */
`timescale 1ns/1ps

module dataStore (
  input  logic                                clk,
  input  dcachePkg::index_t                   index_i,
  input  logic                                way_i,
  input  logic [$clog2(dcachePkg::BEATS)-1:0] wordSel_i,
  input  logic                                storeEn_i,
  input  dcachePkg::sel_t                     storeSel_i,
  input  dcachePkg::word_t                    storeData_i,
  input  logic                                fillEn_i,
  input  dcachePkg::line_t                    fillLine_i,
  output dcachePkg::word_t                    word_o,
  output dcachePkg::line_t                    line_o
);

  // one line array per way
  dcachePkg::line_t lineMem [2][dcachePkg::SETS];

  dcachePkg::line_t curLine;
  dcachePkg::word_t curWord;
  dcachePkg::word_t mergedWord;

  // combinational read of the selected way
  assign curLine = lineMem[way_i][index_i];
  assign curWord = curLine[wordSel_i*dcachePkg::DATA_W +: dcachePkg::DATA_W];

  // byte merge under the select mask
  always_comb begin
    mergedWord = curWord;
    for (int b = 0; b < dcachePkg::SEL_W; b++) begin
      if (storeSel_i[b]) begin
        mergedWord[b*8 +: 8] = storeData_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineMem[way_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      lineMem[way_i][index_i][wordSel_i*dcachePkg::DATA_W +: dcachePkg::DATA_W] <= mergedWord;
    end
  end

  assign word_o = curWord;
  // whole line goes to the writeback engine
  assign line_o = curLine;

endmodule

/* rtl/dcacheCtrl.sv */
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  dcachePkg::wbReq_t                   cpuReq_i,
  input  logic                                fillDone_i,
  input  logic                                wbBusy_i,
  input  dcachePkg::word_t                    storeWord_i,
  output dcachePkg::wbRsp_t                   cpuRsp_o,
  output dcachePkg::index_t                   index_o,
  output logic                                way_o,
  output logic [$clog2(dcachePkg::BEATS)-1:0] wordSel_o,
  output logic                                storeEn_o,
  output dcachePkg::sel_t                     storeSel_o,
  output dcachePkg::word_t                    storeData_o,
  output logic                                fillEn_o,
  output logic                                refillStart_o,
  output dcachePkg::addr_t                    refillAddr_o,
  output logic                                wbStart_o,
  output dcachePkg::addr_t                    wbAddr_o
);

  dcachePkg::ctrlState_e stateQ;
  dcachePkg::ctrlState_e stateD;

  // latched cpu request
  dcachePkg::addr_t  reqAdr;
  logic              reqWe;
  dcachePkg::sel_t   reqSel;
  dcachePkg::word_t  reqDat;
  dcachePkg::tag_t   reqTag;
  dcachePkg::index_t reqIndex;

  dcachePkg::tag_t            tagMem [2][dcachePkg::SETS];
  logic [dcachePkg::SETS-1:0] validQ [2];
  logic [dcachePkg::SETS-1:0] dirtyQ [2];

  logic       victimQ;
  logic       fillWayQ;
  logic [1:0] wayHit;
  logic       hit;
  logic       hitWay;
  logic       victimDirty;
  logic       lookupEn;
  logic       missGo;

  assign reqTag   = reqAdr[dcachePkg::ADDR_W-1 -: dcachePkg::TAG_W];
  assign reqIndex = reqAdr[dcachePkg::OFFSET_W +: dcachePkg::INDEX_W];

  // tag compare on both ways
  assign wayHit[0] = validQ[0][reqIndex] && (tagMem[0][reqIndex] == reqTag);
  assign wayHit[1] = validQ[1][reqIndex] && (tagMem[1][reqIndex] == reqTag);
  assign hit       = |wayHit;
  assign hitWay    = wayHit[1];

  assign victimDirty = validQ[victimQ][reqIndex] && dirtyQ[victimQ][reqIndex];
  assign lookupEn    = (stateQ == dcachePkg::LOOKUP);
  // a dirty victim has to wait for the previous writeback to drain
  assign missGo      = lookupEn && !hit && !(victimDirty && wbBusy_i);

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      dcachePkg::IDLE: begin
        if (cpuReq_i.cyc && cpuReq_i.stb) begin
          stateD = dcachePkg::LOOKUP;
        end
      end
      dcachePkg::LOOKUP: begin
        if (hit) begin
          stateD = dcachePkg::IDLE;
        end else if (missGo) begin
          stateD = dcachePkg::FETCH;
        end
      end
      dcachePkg::FETCH: begin
        if (fillDone_i) begin
          stateD = dcachePkg::INSTALL;
        end
      end
      default: begin
        stateD = dcachePkg::LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ   <= dcachePkg::IDLE;
      victimQ  <= 1'b0;
      fillWayQ <= 1'b0;
      validQ   <= '{default: '0};
      dirtyQ   <= '{default: '0};
    end else begin
      stateQ <= stateD;
      // toggle victim choice on every launched miss
      if (missGo) begin
        victimQ  <= ~victimQ;
        fillWayQ <= victimQ;
      end
      if (fillEn_o) begin
        validQ[fillWayQ][reqIndex] <= 1'b1;
        dirtyQ[fillWayQ][reqIndex] <= 1'b0;
      end else if (storeEn_o) begin
        dirtyQ[hitWay][reqIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stateQ == dcachePkg::IDLE && cpuReq_i.cyc && cpuReq_i.stb) begin
      reqAdr <= cpuReq_i.adr;
      reqWe  <= cpuReq_i.we;
      reqSel <= cpuReq_i.sel;
      reqDat <= cpuReq_i.dat;
    end
    if (fillEn_o) begin
      tagMem[fillWayQ][reqIndex] <= reqTag;
    end
  end

  // install targets the remembered way, otherwise hit way or victim
  assign way_o       = fillEn_o ? fillWayQ : (hit ? hitWay : victimQ);
  assign index_o     = reqIndex;
  assign wordSel_o   = reqAdr[dcachePkg::OFFSET_W-1 -: $clog2(dcachePkg::BEATS)];
  assign storeEn_o   = lookupEn && hit && reqWe;
  assign storeSel_o  = reqSel;
  assign storeData_o = reqDat;
  assign fillEn_o    = (stateQ == dcachePkg::INSTALL);

  assign refillStart_o = missGo;
  assign refillAddr_o  = {reqTag, reqIndex, {dcachePkg::OFFSET_W{1'b0}}};
  assign wbStart_o     = missGo && victimDirty;
  assign wbAddr_o      = {tagMem[victimQ][reqIndex], reqIndex, {dcachePkg::OFFSET_W{1'b0}}};

  always_comb begin
    cpuRsp_o.ack = lookupEn && hit;
    cpuRsp_o.dat = storeWord_i;
  end

endmodule

/* rtl/dcachePkg.sv */
package dcachePkg;

  // cache geometry
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int SEL_W    = DATA_W / 8;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int SETS     = 1 << INDEX_W;
  localparam int BEATS    = 4;
  localparam int LINE_W   = BEATS * DATA_W;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  word_t;
  typedef logic [SEL_W-1:0]   sel_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  // word 0 sits in the low bits
  typedef logic [LINE_W-1:0]  line_t;

  // wishbone classic request, same layout on cpu and memory side
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    word_t dat;
  } wbReq_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wbRsp_t;

  // lookup FSM
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    FETCH,
    INSTALL
  } ctrlState_e;

endpackage

/* rtl/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::wbReq_t cpuReq_i,
  input  dcachePkg::wbRsp_t memRsp_i,
  output dcachePkg::wbRsp_t cpuRsp_o,
  output dcachePkg::wbReq_t memReq_o
);

  dcachePkg::index_t                   index;
  logic                                way;
  logic [$clog2(dcachePkg::BEATS)-1:0] wordSel;
  logic                                storeEn;
  dcachePkg::sel_t                     storeSel;
  dcachePkg::word_t                    storeData;
  dcachePkg::word_t                    storeWord;
  logic                                fillEn;
  dcachePkg::line_t                    fillLine;
  dcachePkg::line_t                    curLine;
  logic                                fillDone;
  logic                                refillStart;
  dcachePkg::addr_t                    refillAddr;
  logic                                wbStart;
  dcachePkg::addr_t                    wbAddr;
  logic                                wbBusy;

  // per-engine bus pairs into the arbiter
  dcachePkg::wbReq_t fillReq;
  dcachePkg::wbRsp_t fillRsp;
  dcachePkg::wbReq_t wbReq;
  dcachePkg::wbRsp_t wbRsp;

  dcacheCtrl uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpuReq_i      (cpuReq_i),
    .fillDone_i    (fillDone),
    .wbBusy_i      (wbBusy),
    .storeWord_i   (storeWord),
    .cpuRsp_o      (cpuRsp_o),
    .index_o       (index),
    .way_o         (way),
    .wordSel_o     (wordSel),
    .storeEn_o     (storeEn),
    .storeSel_o    (storeSel),
    .storeData_o   (storeData),
    .fillEn_o      (fillEn),
    .refillStart_o (refillStart),
    .refillAddr_o  (refillAddr),
    .wbStart_o     (wbStart),
    .wbAddr_o      (wbAddr)
  );

  dataStore uStore (
    .clk         (clk),
    .index_i     (index),
    .way_i       (way),
    .wordSel_i   (wordSel),
    .storeEn_i   (storeEn),
    .storeSel_i  (storeSel),
    .storeData_i (storeData),
    .fillEn_i    (fillEn),
    .fillLine_i  (fillLine),
    .word_o      (storeWord),
    .line_o      (curLine)
  );

  lineRefill uRefill (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (refillStart),
    .lineAddr_i (refillAddr),
    .busRsp_i   (fillRsp),
    .busReq_o   (fillReq),
    .done_o     (fillDone),
    .line_o     (fillLine)
  );

  lineWriteback uWriteback (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (wbStart),
    .lineAddr_i (wbAddr),
    .line_i     (curLine),
    .busRsp_i   (wbRsp),
    .busReq_o   (wbReq),
    .busy_o     (wbBusy)
  );

  memArbiter uArbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .wbReq_i   (wbReq),
    .fillReq_i (fillReq),
    .memRsp_i  (memRsp_i),
    .wbRsp_o   (wbRsp),
    .fillRsp_o (fillRsp),
    .memReq_o  (memReq_o)
  );

endmodule

/* rtl/lineRefill.sv */
`timescale 1ns/1ps

module lineRefill (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  dcachePkg::addr_t  lineAddr_i,
  input  dcachePkg::wbRsp_t busRsp_i,
  output dcachePkg::wbReq_t busReq_o,
  output logic              done_o,
  output dcachePkg::line_t  line_o
);

  logic                                busyQ;
  logic                                doneQ;
  logic [$clog2(dcachePkg::BEATS)-1:0] beatQ;
  dcachePkg::addr_t                    baseQ;
  dcachePkg::line_t                    lineQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busyQ <= 1'b0;
      doneQ <= 1'b0;
      beatQ <= '0;
    end else begin
      doneQ <= 1'b0;
      if (start_i) begin
        busyQ <= 1'b1;
        beatQ <= '0;
      end else if (busyQ && busRsp_i.ack) begin
        beatQ <= beatQ + 1'b1;
        // last beat ends the burst
        if (beatQ == $clog2(dcachePkg::BEATS)'(dcachePkg::BEATS - 1)) begin
          busyQ <= 1'b0;
          doneQ <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      baseQ <= lineAddr_i;
    end
    if (busyQ && busRsp_i.ack) begin
      lineQ[beatQ*dcachePkg::DATA_W +: dcachePkg::DATA_W] <= busRsp_i.dat;
    end
  end

  // read beats at consecutive word addresses
  always_comb begin
    busReq_o     = '0;
    busReq_o.cyc = busyQ;
    busReq_o.stb = busyQ;
    busReq_o.we  = 1'b0;
    busReq_o.sel = '1;
    busReq_o.adr = {baseQ[dcachePkg::ADDR_W-1:dcachePkg::OFFSET_W], beatQ,
                    {$clog2(dcachePkg::SEL_W){1'b0}}};
  end

  assign done_o = doneQ;
  assign line_o = lineQ;

endmodule

/* rtl/lineWriteback.sv */
`timescale 1ns/1ps

module lineWriteback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  dcachePkg::addr_t  lineAddr_i,
  input  dcachePkg::line_t  line_i,
  input  dcachePkg::wbRsp_t busRsp_i,
  output dcachePkg::wbReq_t busReq_o,
  output logic              busy_o
);

  logic                                busyQ;
  logic [$clog2(dcachePkg::BEATS)-1:0] beatQ;
  dcachePkg::addr_t                    baseQ;
  dcachePkg::line_t                    lineQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busyQ <= 1'b0;
      beatQ <= '0;
    end else if (start_i) begin
      busyQ <= 1'b1;
      beatQ <= '0;
    end else if (busyQ && busRsp_i.ack) begin
      beatQ <= beatQ + 1'b1;
      if (beatQ == $clog2(dcachePkg::BEATS)'(dcachePkg::BEATS - 1)) begin
        busyQ <= 1'b0;
      end
    end
  end

  // snapshot victim, the install may overwrite the way right after
  always_ff @(posedge clk) begin
    if (start_i) begin
      baseQ <= lineAddr_i;
      lineQ <= line_i;
    end
  end

  always_comb begin
    busReq_o     = '0;
    busReq_o.cyc = busyQ;
    busReq_o.stb = busyQ;
    busReq_o.we  = 1'b1;
    busReq_o.sel = '1;
    busReq_o.adr = {baseQ[dcachePkg::ADDR_W-1:dcachePkg::OFFSET_W], beatQ,
                    {$clog2(dcachePkg::SEL_W){1'b0}}};
    busReq_o.dat = lineQ[beatQ*dcachePkg::DATA_W +: dcachePkg::DATA_W];
  end

  assign busy_o = busyQ;

endmodule

/* rtl/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::wbReq_t wbReq_i,
  input  dcachePkg::wbReq_t fillReq_i,
  input  dcachePkg::wbRsp_t memRsp_i,
  output dcachePkg::wbRsp_t wbRsp_o,
  output dcachePkg::wbRsp_t fillRsp_o,
  output dcachePkg::wbReq_t memReq_o
);

  // owner register, ownWbQ picks the engine while busyQ is set
  logic busyQ;
  logic ownWbQ;
  logic ownerCyc;

  assign ownerCyc = ownWbQ ? wbReq_i.cyc : fillReq_i.cyc;

  // regrant only once the owner has dropped cyc, writeback first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busyQ  <= 1'b0;
      ownWbQ <= 1'b0;
    end else if (!busyQ || !ownerCyc) begin
      busyQ  <= wbReq_i.cyc || fillReq_i.cyc;
      ownWbQ <= wbReq_i.cyc;
    end
  end

  always_comb begin
    if (busyQ) begin
      memReq_o = ownWbQ ? wbReq_i : fillReq_i;
    end else begin
      memReq_o = '0;
    end
  end

  // ack goes to the owner only
  always_comb begin
    wbRsp_o.ack   = memRsp_i.ack && busyQ && ownWbQ;
    wbRsp_o.dat   = memRsp_i.dat;
    fillRsp_o.ack = memRsp_i.ack && busyQ && !ownWbQ;
    fillRsp_o.dat = memRsp_i.dat;
  end

endmodule

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dcacheTb -f vlog.f -o simv > build.log 2>&1 &&
  ./obj_dir/simv > sim.log 2>&1 ||
  echo "build or simulation stopped early, see build.log and sim.log"
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int MEM_WORDS    = 2048;
  localparam int NUM_RAND     = 300;
  localparam int NUM_MASK     = 40;
  localparam int CONF_ROUNDS  = 4;
  localparam int NUM_HIT      = 40;
  // every transaction the stimulus issues, sizes the watchdog
  localparam int TOTAL_TXN = NUM_RAND + 2 * NUM_MASK + CONF_ROUNDS * 3 * 2 + 2 * NUM_HIT;
  localparam int LIMIT_CYCLES = RESET_CYCLES + TOTAL_TXN * 200;

  logic              clk;
  logic              rst_n;
  dcachePkg::wbReq_t cpuReq;
  dcachePkg::wbRsp_t cpuRsp;
  dcachePkg::wbReq_t memReq;
  dcachePkg::wbRsp_t memRsp;

  // 16 KB memory and the golden view the cpu should see
  logic [63:0] mem        [MEM_WORDS];
  logic [63:0] golden     [MEM_WORDS];
  logic        storedLine [MEM_WORDS/4];

  integer      seed;
  int          waitCnt;
  int          wbBeats;
  int          checkCount;
  int          errCount;
  int          testChecks;
  int          testErrors;
  string       curTest;
  logic [10:0] memIdx;

  dcacheTop UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpuReq_i (cpuReq),
    .memRsp_i (memRsp),
    .cpuRsp_o (cpuRsp),
    .memReq_o (memReq)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [63:0] byteMask(input logic [7:0] sel);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[b*8 +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  // word-aligned, anywhere in the 16 KB window
  function automatic logic [31:0] randAddr();
    logic [31:0] r;
    r = $random(seed);
    return {18'd0, r[13:3], 3'd0};
  endfunction

  task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
    checkCount++;
    testChecks++;
    if (expected !== actual) begin
      errCount++;
      testErrors++;
      $display("[ERROR] %s %s: expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic endTest();
    $display("test %s done: %0d checks, %0d errors", curTest, testChecks, testErrors);
  endtask

  // one wishbone transfer, entered just after a rising edge
  task automatic cpuAccess(input logic we, input logic [31:0] adr, input logic [7:0] sel,
                           input logic [63:0] dat, output logic [63:0] rdat,
                           output int cycles);
    logic [10:0] idx;
    idx        = adr[13:3];
    cpuReq.cyc = 1'b1;
    cpuReq.stb = 1'b1;
    cpuReq.we  = we;
    cpuReq.sel = sel;
    cpuReq.adr = adr;
    cpuReq.dat = dat;
    cycles     = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cpuRsp.ack);
    rdat = cpuRsp.dat;
    if (we) begin
      golden[idx] = (golden[idx] & ~byteMask(sel)) | (dat & byteMask(sel));
      storedLine[idx[10:2]] = 1'b1;
    end
    @(posedge clk);
    #1;
    cpuReq = '0;
  endtask

  task automatic doLoad(input logic [31:0] adr, output logic [63:0] rdat, output int cycles);
    cpuAccess(1'b0, adr, 8'h00, 64'd0, rdat, cycles);
    check("load data", golden[adr[13:3]], rdat);
  endtask

  task automatic doStore(input logic [31:0] adr, output logic [7:0] sel);
    logic [63:0] rdat;
    logic [63:0] dat;
    logic [31:0] r;
    int          cycles;
    dat = {$random(seed), $random(seed)};
    r   = $random(seed);
    sel = r[7:0];
    cpuAccess(1'b1, adr, sel, dat, rdat, cycles);
  endtask

  // memory slave, 0 to 3 wait states and an idle cycle after each ack
  always @(posedge clk) begin
    #1;
    if (!rst_n || memRsp.ack) begin
      memRsp.ack = 1'b0;
    end else if (memReq.cyc && memReq.stb) begin
      if (waitCnt > 0) begin
        waitCnt--;
      end else begin
        memIdx = memReq.adr[13:3];
        if (memReq.we) begin
          check("writeback data", golden[memIdx], memReq.dat);
          check("writeback of a stored line", 64'd1, {63'd0, storedLine[memIdx[10:2]]});
          mem[memIdx] = (mem[memIdx] & ~byteMask(memReq.sel)) |
                        (memReq.dat & byteMask(memReq.sel));
          wbBeats++;
        end else begin
          memRsp.dat = mem[memIdx];
        end
        memRsp.ack = 1'b1;
        waitCnt    = $random(seed) & 3;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] adr;
    logic [31:0] r;
    logic [63:0] oldWord;
    logic [63:0] rdat;
    logic [7:0]  sel;
    logic [2:0]  tagBase;
    logic [5:0]  setIdx;
    int          cycles;
    int          beatsBefore;

    seed       = 32'hd644;
    rst_n      = 1'b0;
    cpuReq     = '0;
    memRsp     = '0;
    waitCnt    = 0;
    wbBeats    = 0;
    checkCount = 0;
    errCount   = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = {$random(seed), $random(seed)};
      golden[i] = mem[i];
    end
    for (int i = 0; i < MEM_WORDS/4; i++) begin
      storedLine[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    startTest("reset");
    repeat (5) begin
      @(negedge clk);
      check("cpu ack", 64'd0, 64'(cpuRsp.ack));
      check("memory cyc", 64'd0, 64'(memReq.cyc));
    end
    @(posedge clk);
    #1;
    endTest();

    startTest("load data");
    for (int i = 0; i < NUM_RAND; i++) begin
      r   = $random(seed);
      adr = randAddr();
      if (r[0]) begin
        doStore(adr, sel);
      end else begin
        doLoad(adr, rdat, cycles);
      end
    end
    endTest();

    startTest("masked stores");
    for (int i = 0; i < NUM_MASK; i++) begin
      adr     = randAddr();
      oldWord = golden[adr[13:3]];
      doStore(adr, sel);
      doLoad(adr, rdat, cycles);
      check("unselected bytes", oldWord & ~byteMask(sel), rdat & ~byteMask(sel));
    end
    endTest();

    // three tags rotating through one two-way set
    startTest("dirty writeback");
    r           = $random(seed);
    setIdx      = r[5:0];
    tagBase     = r[8:6];
    beatsBefore = wbBeats;
    for (int k = 0; k < CONF_ROUNDS * 3; k++) begin
      r   = $random(seed);
      adr = {18'd0, tagBase + 3'(k % 3), setIdx, r[1:0], 3'd0};
      doStore(adr, sel);
    end
    for (int k = 0; k < CONF_ROUNDS * 3; k++) begin
      adr = {18'd0, tagBase + 3'(k % 3), setIdx, 2'(k / 3), 3'd0};
      doLoad(adr, rdat, cycles);
    end
    check("writeback beats seen", 64'd1, 64'(wbBeats > beatsBefore));
    endTest();

    startTest("hit latency");
    for (int i = 0; i < NUM_HIT; i++) begin
      r   = $random(seed);
      adr = randAddr();
      if (r[2]) begin
        doStore(adr, sel);
      end else begin
        doLoad(adr, rdat, cycles);
      end
      adr[4:3] = r[1:0];
      doLoad(adr, rdat, cycles);
      check("hit latency cycles", 64'd2, 64'(cycles));
    end
    endTest();

    $display("total: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

/* verification/dcache_asserts.sv */
`timescale 1ns/1ps

module dcacheAsserts (
  input logic              clk,
  input logic              rst_n,
  input dcachePkg::wbReq_t cpuReq_i,
  input dcachePkg::wbRsp_t cpuRsp_i,
  input dcachePkg::wbReq_t memReq_i,
  input dcachePkg::wbRsp_t memRsp_i
);

  // cpu ack only answers a live request
  cpuAckHasReq: assert property (@(posedge clk) disable iff (!rst_n)
    cpuRsp_i.ack |-> (cpuReq_i.cyc && cpuReq_i.stb))
    else $error("cpu ack without cyc and stb");

  memStbHasCyc: assert property (@(posedge clk) disable iff (!rst_n)
    memReq_i.stb |-> memReq_i.cyc)
    else $error("memory stb without cyc");

  // single-cycle acks on both ports
  cpuAckOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
    cpuRsp_i.ack |-> !$past(cpuRsp_i.ack))
    else $error("cpu ack high in two consecutive cycles");

  memAckOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
    memRsp_i.ack |-> !$past(memRsp_i.ack))
    else $error("memory ack high in two consecutive cycles");

endmodule

bind dcacheTop dcacheAsserts uAsserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cpuReq_i (cpuReq_i),
  .cpuRsp_i (cpuRsp_o),
  .memReq_i (memReq_o),
  .memRsp_i (memRsp_i)
);

/* vlog.f */
rtl/dcachePkg.sv
rtl/dcacheCtrl.sv
rtl/dataStore.sv
rtl/lineRefill.sv
rtl/lineWriteback.sv
rtl/memArbiter.sv
rtl/dcacheTop.sv
verification/dcache_asserts.sv
verification/dcacheTb.sv
